// ==== hw/avalonPkg.sv ====
package avalonPkg;

    // bus widths, address is a word address
    localparam int AddrWidth = 30;
    localparam int DataWidth = 32;
    localparam int ByteEnWidth = DataWidth / 8;

    // masters sharing the single slave port
    localparam int NumMasters = 3;
    // select value 0 means no grant, 1..NumMasters name a master
    localparam int SelWidth = $clog2(NumMasters + 1);

    // command from one master, held until waitRequest is sampled low
    typedef struct packed {
        logic [AddrWidth-1:0]   addr;
        logic [ByteEnWidth-1:0] byteEn;
        logic                   read;
        logic                   write;
        logic [DataWidth-1:0]   writeData;
    } avCmd_t;

    // response toward a master
    typedef struct packed {
        logic [DataWidth-1:0] readData;
        logic                 waitRequest;
    } avRsp_t;

endpackage

// ==== hw/memMapPkg.sv ====
package memMapPkg;

    // address bit 29 set selects the register block, clear selects the RAM
    localparam int RegSpaceBit = 29;

    // scratch RAM size, indexed by the low address bits
    localparam int RamDepth = 256;
    localparam int RamAddrWidth = $clog2(RamDepth);

    // register word offsets below RegSpaceBit
    localparam logic [RegSpaceBit-1:0] RegScratch = 'd0;
    localparam logic [RegSpaceBit-1:0] RegId = 'd1;
    localparam logic [RegSpaceBit-1:0] RegWriteCount = 'd2;

    // value returned by the identification register
    localparam logic [31:0] RegIdValue = 32'h5A17_B0F5;

endpackage

// ==== hw/busArbiter.sv ====
module busArbiter (
    input  logic                           i_Clk,
    input  logic                           i_arstN,

    // read or write request per master
    input  logic [avalonPkg::NumMasters-1:0] i_Req,
    // waitRequest of the shared slave port
    input  logic                           i_WaitRequest,

    output logic [avalonPkg::SelWidth-1:0]   o_MuxSel
);
    import avalonPkg::*;

    logic [SelWidth-1:0] r_Grant;
    logic [SelWidth-1:0] w_NextGrant;
    logic                w_OwnerReq;
    logic                w_Accept;
    logic                w_Release;

    // request of the current owner, zero when nobody is granted
    always_comb begin
        w_OwnerReq = 1'b0;
        if (r_Grant != '0) begin
            w_OwnerReq = i_Req[r_Grant - 1'b1];
        end
    end

    assign w_Accept = w_OwnerReq & ~i_WaitRequest;
    assign w_Release = (r_Grant == '0) | ~w_OwnerReq | w_Accept;

    // round-robin search starting at the master after the owner,
    // the owner itself is the last candidate
    always_comb begin
        int idx;
        w_NextGrant = '0;
        for (int k = NumMasters - 1; k >= 0; k--) begin
            idx = (int'(r_Grant) + k) % NumMasters;
            if (i_Req[idx]) begin
                w_NextGrant = SelWidth'(idx + 1);
            end
        end
    end

    // grant only moves when the owner is done or gone
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            r_Grant <= '0;
        end else if (w_Release) begin
            r_Grant <= w_NextGrant;
        end
    end

    assign o_MuxSel = r_Grant;

    // owner may only have dropped its request right after its transfer was accepted
    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        (r_Grant != '0 && !w_OwnerReq) |-> $past(w_Accept))
    else $error("grant held by a master that is not requesting");

endmodule

// ==== hw/busMux.sv ====
module busMux (
    input  logic                                     i_Clk,
    input  logic                                     i_arstN,

    input  logic [avalonPkg::SelWidth-1:0]             i_MuxSel,

    // master side
    input  avalonPkg::avCmd_t [avalonPkg::NumMasters-1:0] i_MstCmd,
    output avalonPkg::avRsp_t [avalonPkg::NumMasters-1:0] o_MstRsp,

    // shared slave side
    output avalonPkg::avCmd_t                          o_SlvCmd,
    input  avalonPkg::avRsp_t                          i_SlvRsp
);
    import avalonPkg::*;

    logic [SelWidth-1:0]   r_OldMuxSel;

    // granted command to the slave, idle command when nobody is granted
    always_comb begin
        o_SlvCmd = '0;
        if (i_MuxSel != '0) begin
            o_SlvCmd = i_MstCmd[i_MuxSel - 1'b1];
        end
    end

    // waitRequest only reaches the granted master,
    // read data goes to the master granted one cycle earlier
    always_comb begin
        for (int m = 0; m < NumMasters; m++) begin
            if (i_MuxSel == SelWidth'(m + 1)) begin
                o_MstRsp[m].waitRequest = i_SlvRsp.waitRequest;
            end else begin
                o_MstRsp[m].waitRequest = 1'b1;
            end
            if (r_OldMuxSel == SelWidth'(m + 1)) begin
                o_MstRsp[m].readData = i_SlvRsp.readData;
            end else begin
                o_MstRsp[m].readData = '0;
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            r_OldMuxSel <= '0;
        end else begin
            r_OldMuxSel <= i_MuxSel;
        end
    end

    // slave back-pressure keeps the grant and the granted command steady
    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        (i_MuxSel != '0 && (o_SlvCmd.read || o_SlvCmd.write) && i_SlvRsp.waitRequest)
        |=> ($stable(i_MuxSel) && $stable(o_SlvCmd)))
    else $error("grant or command changed while the slave held waitRequest");

endmodule

// ==== hw/slaveDecoder.sv ====
module slaveDecoder (
    input  logic              i_Clk,
    input  logic              i_arstN,

    // shared port from the multiplexer
    input  avalonPkg::avCmd_t i_Cmd,
    output avalonPkg::avRsp_t o_Rsp,

    // scratch RAM target
    output avalonPkg::avCmd_t o_RamCmd,
    input  avalonPkg::avRsp_t i_RamRsp,

    // register block target
    output avalonPkg::avCmd_t o_RegCmd,
    input  avalonPkg::avRsp_t i_RegRsp
);
    import avalonPkg::*;
    import memMapPkg::*;

    logic w_RegSel;
    logic w_ReadAccept;
    // target that accepted the last read
    logic r_RdFromReg;

    assign w_RegSel = i_Cmd.addr[RegSpaceBit];

    // both targets see the command, only the decoded one sees a strobe
    always_comb begin
        o_RamCmd = i_Cmd;
        o_RegCmd = i_Cmd;
        o_RamCmd.read = i_Cmd.read & ~w_RegSel;
        o_RamCmd.write = i_Cmd.write & ~w_RegSel;
        o_RegCmd.read = i_Cmd.read & w_RegSel;
        o_RegCmd.write = i_Cmd.write & w_RegSel;
    end

    assign o_Rsp.waitRequest = w_RegSel ? i_RegRsp.waitRequest : i_RamRsp.waitRequest;
    assign w_ReadAccept = i_Cmd.read & ~o_Rsp.waitRequest;

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            r_RdFromReg <= 1'b0;
        end else if (w_ReadAccept) begin
            r_RdFromReg <= w_RegSel;
        end
    end

    // targets drive zero outside their read data cycle
    assign o_Rsp.readData = r_RdFromReg ? i_RegRsp.readData : i_RamRsp.readData;

endmodule

// ==== hw/scratchRam.sv ====
module scratchRam (
    input  logic              i_Clk,
    input  logic              i_arstN,

    input  avalonPkg::avCmd_t i_Cmd,
    output avalonPkg::avRsp_t o_Rsp
);
    import avalonPkg::*;
    import memMapPkg::*;

    logic [DataWidth-1:0]    r_Mem [RamDepth];
    logic [DataWidth-1:0]    r_ReadData;
    logic [RamAddrWidth-1:0] w_Index;

    // word index from the low address bits
    assign w_Index = i_Cmd.addr[RamAddrWidth-1:0];

    // byte lane writes
    always_ff @(posedge i_Clk) begin
        if (i_Cmd.write) begin
            for (int b = 0; b < ByteEnWidth; b++) begin
                if (i_Cmd.byteEn[b]) begin
                    r_Mem[w_Index][8*b +: 8] <= i_Cmd.writeData[8*b +: 8];
                end
            end
        end
    end

    // read word is valid for one cycle only
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            r_ReadData <= '0;
        end else if (i_Cmd.read) begin
            r_ReadData <= r_Mem[w_Index];
        end else begin
            r_ReadData <= '0;
        end
    end

    // zero wait states
    assign o_Rsp.waitRequest = 1'b0;
    assign o_Rsp.readData = r_ReadData;

endmodule

// ==== hw/statusRegs.sv ====
module statusRegs (
    input  logic              i_Clk,
    input  logic              i_arstN,

    input  avalonPkg::avCmd_t i_Cmd,
    output avalonPkg::avRsp_t o_Rsp
);
    import avalonPkg::*;
    import memMapPkg::*;

    logic [RegSpaceBit-1:0] w_Offset;
    logic                   w_Access;
    logic                   w_Accept;
    // set after the first cycle of an access
    logic                   r_WaitDone;
    logic [DataWidth-1:0]   r_Scratch;
    logic [DataWidth-1:0]   r_WriteCount;
    logic [DataWidth-1:0]   r_ReadData;
    logic [DataWidth-1:0]   w_RegValue;

    assign w_Offset = i_Cmd.addr[RegSpaceBit-1:0];
    assign w_Access = i_Cmd.read | i_Cmd.write;
    assign w_Accept = w_Access & r_WaitDone;

    // register read mux, unmapped offsets read zero
    always_comb begin
        case (w_Offset)
            RegScratch:    w_RegValue = r_Scratch;
            RegId:         w_RegValue = RegIdValue;
            RegWriteCount: w_RegValue = r_WriteCount;
            default:       w_RegValue = '0;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            r_WaitDone <= 1'b0;
            r_Scratch <= '0;
            r_WriteCount <= '0;
            r_ReadData <= '0;
        end else begin
            r_WaitDone <= w_Access & ~r_WaitDone;
            r_ReadData <= (w_Accept && i_Cmd.read) ? w_RegValue : '0;
            if (w_Accept && i_Cmd.write) begin
                // counts every write, wraps at 32 bits
                r_WriteCount <= r_WriteCount + 1'b1;
                if (w_Offset == RegScratch) begin
                    for (int b = 0; b < ByteEnWidth; b++) begin
                        if (i_Cmd.byteEn[b]) begin
                            r_Scratch[8*b +: 8] <= i_Cmd.writeData[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // one wait state per access
    assign o_Rsp.waitRequest = w_Access & ~r_WaitDone;
    assign o_Rsp.readData = r_ReadData;

    assert property (@(posedge i_Clk) disable iff (!i_arstN) !(i_Cmd.read && i_Cmd.write))
    else $error("read and write set together");

endmodule

// ==== hw/busFabric.sv ====
module busFabric (
    input  logic                                     i_Clk,
    input  logic                                     i_arstN,

    input  avalonPkg::avCmd_t [avalonPkg::NumMasters-1:0] i_MstCmd,
    output avalonPkg::avRsp_t [avalonPkg::NumMasters-1:0] o_MstRsp
);
    import avalonPkg::*;

    logic [NumMasters-1:0] w_Req;
    logic [SelWidth-1:0]   w_MuxSel;
    avCmd_t                w_SlvCmd;
    avCmd_t                w_RamCmd;
    avCmd_t                w_RegCmd;
    avRsp_t                w_SlvRsp;
    avRsp_t                w_RamRsp;
    avRsp_t                w_RegRsp;

    // a master requests while it holds read or write
    for (genvar m = 0; m < NumMasters; m++) begin : reqGen
        assign w_Req[m] = i_MstCmd[m].read | i_MstCmd[m].write;
    end

    busArbiter busArbiter_i (
        .i_Clk         (i_Clk),
        .i_arstN       (i_arstN),
        .i_Req         (w_Req),
        .i_WaitRequest (w_SlvRsp.waitRequest),
        .o_MuxSel      (w_MuxSel)
    );

    busMux busMux_i (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_MuxSel (w_MuxSel),
        .i_MstCmd (i_MstCmd),
        .o_MstRsp (o_MstRsp),
        .o_SlvCmd (w_SlvCmd),
        .i_SlvRsp (w_SlvRsp)
    );

    slaveDecoder slaveDecoder_i (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_Cmd    (w_SlvCmd),
        .o_Rsp    (w_SlvRsp),
        .o_RamCmd (w_RamCmd),
        .i_RamRsp (w_RamRsp),
        .o_RegCmd (w_RegCmd),
        .i_RegRsp (w_RegRsp)
    );

    scratchRam scratchRam_i (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .i_Cmd   (w_RamCmd),
        .o_Rsp   (w_RamRsp)
    );

    statusRegs statusRegs_i (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .i_Cmd   (w_RegCmd),
        .o_Rsp   (w_RegRsp)
    );

endmodule

// ==== tb/busFabricTb.sv ====
module busFabricTb;
    import avalonPkg::*;
    import memMapPkg::*;

    // all tests together take a few hundred cycles
    localparam int TimeoutCycles = 2000;

    logic clk;
    logic arstN;
    avCmd_t [NumMasters-1:0] mstCmd;
    avRsp_t [NumMasters-1:0] mstRsp;

    int seed = 87938;
    int errCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    logic [DataWidth-1:0] ramModel [RamDepth];
    logic [AddrWidth-1:0] ramAddr [8];
    int acceptOrder [$];

    busFabric busFabric_i (
        .i_Clk    (clk),
        .i_arstN  (arstN),
        .i_MstCmd (mstCmd),
        .o_MstRsp (mstRsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

    // only the granted master may see waitRequest low
    always @(negedge clk) begin : waitMonitor
        int lows;
        lows = 0;
        for (int m = 0; m < NumMasters; m++) begin
            if (!mstRsp[m].waitRequest) begin
                lows++;
            end
        end
        if (arstN) begin
            assert (lows <= 1) else begin
                errCount++;
                $display("%0t: %0d masters see waitRequest low at once", $time, lows);
            end
        end
    end

    function automatic avCmd_t makeCmd(input logic isWrite, input logic [AddrWidth-1:0] addr,
                                       input logic [ByteEnWidth-1:0] be,
                                       input logic [DataWidth-1:0] data);
        avCmd_t cmd;
        cmd.addr = addr;
        cmd.byteEn = be;
        cmd.read = ~isWrite;
        cmd.write = isWrite;
        cmd.writeData = data;
        return cmd;
    endfunction

    // only enabled byte lanes take the new data
    function automatic logic [DataWidth-1:0] mergeBytes(input logic [DataWidth-1:0] oldWord,
                                                        input logic [DataWidth-1:0] newWord,
                                                        input logic [ByteEnWidth-1:0] be);
        logic [DataWidth-1:0] result;
        result = oldWord;
        for (int b = 0; b < ByteEnWidth; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [AddrWidth-1:0] regAddr(input logic [RegSpaceBit-1:0] offset);
        return AddrWidth'(1) << RegSpaceBit | AddrWidth'(offset);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one transfer, held until waitRequest is seen low, readData taken a cycle later
    task automatic busXfer(input int m, input logic isWrite, input logic [AddrWidth-1:0] addr,
                           input logic [ByteEnWidth-1:0] be, input logic [DataWidth-1:0] wdata,
                           output logic [DataWidth-1:0] rdata);
        @(posedge clk);
        mstCmd[m] <= makeCmd(isWrite, addr, be, wdata);
        @(negedge clk);
        while (mstRsp[m].waitRequest) @(negedge clk);
        @(posedge clk);
        mstCmd[m].read <= 1'b0;
        mstCmd[m].write <= 1'b0;
        @(negedge clk);
        rdata = mstRsp[m].readData;
    endtask

    task automatic writeWord(input int m, input logic [AddrWidth-1:0] addr,
                             input logic [ByteEnWidth-1:0] be, input logic [DataWidth-1:0] data);
        logic [DataWidth-1:0] rdata;
        busXfer(m, 1'b1, addr, be, data, rdata);
        checkValue($sformatf("o_MstRsp[%0d].readData after write", m), rdata, '0);
    endtask

    task automatic readWord(input int m, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] exp);
        logic [DataWidth-1:0] rdata;
        busXfer(m, 1'b0, addr, '1, '0, rdata);
        checkValue($sformatf("o_MstRsp[%0d].readData", m), rdata, exp);
    endtask

    // back-to-back reads, the next command is presented at acceptance
    task automatic requestStream(input int m, input int n);
        int base;
        logic [DataWidth-1:0] exp;
        base = m * n;
        @(posedge clk);
        mstCmd[m] <= makeCmd(1'b0, ramAddr[base % 8], '1, '0);
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            while (mstRsp[m].waitRequest) @(negedge clk);
            acceptOrder.push_back(m);
            exp = ramModel[ramAddr[(base + i) % 8][RamAddrWidth-1:0]];
            @(posedge clk);
            if (i + 1 < n) begin
                mstCmd[m] <= makeCmd(1'b0, ramAddr[(base + i + 1) % 8], '1, '0);
            end else begin
                mstCmd[m].read <= 1'b0;
            end
            @(negedge clk);
            checkValue($sformatf("o_MstRsp[%0d].readData in stream", m),
                       mstRsp[m].readData, exp);
        end
    endtask

    initial begin
        logic [DataWidth-1:0] data;
        logic [ByteEnWidth-1:0] be;
        logic [DataWidth-1:0] scratchModel;
        int regWrites;
        arstN = 1'b0;
        mstCmd = '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        // reset state
        @(negedge clk);
        for (int m = 0; m < NumMasters; m++) begin
            checkValue($sformatf("o_MstRsp[%0d].waitRequest", m), mstRsp[m].waitRequest, 1);
            checkValue($sformatf("o_MstRsp[%0d].readData", m), mstRsp[m].readData, 0);
        end

        // RAM, one distinct word per 32-word stripe
        for (int i = 0; i < 8; i++) begin
            ramAddr[i] = AddrWidth'(i * 32 + ($random(seed) & 31));
            data = $random(seed);
            writeWord(0, ramAddr[i], '1, data);
            ramModel[ramAddr[i][RamAddrWidth-1:0]] = data;
        end
        for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            be = $random(seed);
            writeWord(0, ramAddr[i], be, data);
            ramModel[ramAddr[i][RamAddrWidth-1:0]] =
                mergeBytes(ramModel[ramAddr[i][RamAddrWidth-1:0]], data, be);
        end
        for (int i = 0; i < 8; i++) begin
            readWord(0, ramAddr[i], ramModel[ramAddr[i][RamAddrWidth-1:0]]);
        end

        // register block
        data = $random(seed);
        writeWord(0, regAddr(RegScratch), '1, data);
        scratchModel = data;
        data = $random(seed);
        be = $random(seed);
        writeWord(0, regAddr(RegScratch), be, data);
        scratchModel = mergeBytes(scratchModel, data, be);
        readWord(0, regAddr(RegScratch), scratchModel);
        writeWord(0, regAddr(RegId), '1, ~RegIdValue);
        readWord(0, regAddr(RegId), RegIdValue);
        readWord(0, regAddr(5), '0);
        regWrites = 3;
        readWord(0, regAddr(RegWriteCount), regWrites);

        // three masters read at the same time
        fork
            readWord(0, ramAddr[0], ramModel[ramAddr[0][RamAddrWidth-1:0]]);
            readWord(1, ramAddr[1], ramModel[ramAddr[1][RamAddrWidth-1:0]]);
            readWord(2, ramAddr[2], ramModel[ramAddr[2][RamAddrWidth-1:0]]);
        join

        // round-robin fairness over nine transfers
        fork
            requestStream(0, 3);
            requestStream(1, 3);
            requestStream(2, 3);
        join
        for (int j = 1; j < acceptOrder.size(); j++) begin
            assert (acceptOrder[j] != acceptOrder[j-1] &&
                    (j < 2 || acceptOrder[j] != acceptOrder[j-2])) else begin
                errCount++;
                $display("master %0d was accepted again before the others had a turn",
                         acceptOrder[j]);
            end
        end

        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/avalonPkg.sv
hw/memMapPkg.sv
hw/busArbiter.sv
hw/busMux.sv
hw/slaveDecoder.sv
hw/scratchRam.sv
hw/statusRegs.sv
hw/busFabric.sv
tb/busFabricTb.sv
